// File: verilog.f
+incdir+include
hdl/dsp_seq_pkg.sv
hdl/dsp_rom_aau.sv
hdl/dsp_decoder.sv
hdl/dsp_do_loop.sv
hdl/dsp_irq_ctl.sv
hdl/dsp_seq_top.sv
bench/dsp_seq_tb.sv

// File: bench/dsp_seq_tb.sv
// ROM is a 4096-word asynchronous table, so upper address bits alias; cen stays high throughout
`timescale 1ns/1ps
`default_nettype none
`include "dsp_seq_settings.svh"

module dsp_seq_tb;

    // Six resets of 8 cycles plus the steps of each test
    localparam int TEST_CYCLES = 6 * 8 + 12 + 14 + 10 + 8 + 163 + 14;
    localparam int MARGIN      = 200;

    logic               clk;
    logic               rst;
    logic               cen;
    logic               irq;
    logic [`DSP_AW-1:0] rom_dout;
    logic [`DSP_AW-1:0] ram_dout;
    logic [`DSP_AW-1:0] acc_dout;
    logic [`DSP_AW-1:0] rom_addr;
    logic [`DSP_AW-1:0] pt_addr;
    logic [`DSP_AW-1:0] reg_dout;
    logic               lfsr_rst;

    logic [`DSP_AW-1:0] rom [0:4095];
    integer             seed   = 31212;
    int                 errors = 0;
    int                 checks = 0;

    assign rom_dout = rom[rom_addr[11:0]];

    dsp_seq_top UUT (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .irq      (irq),
        .rom_dout (rom_dout),
        .ram_dout (ram_dout),
        .acc_dout (acc_dout),
        .rom_addr (rom_addr),
        .pt_addr  (pt_addr),
        .reg_dout (reg_dout),
        .lfsr_rst (lfsr_rst)
    );

    always #10 clk = ~clk;

    task automatic tick();
        @(posedge clk);
        #2;   // Drive point after the edge
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) tick();
        rst = 1'b0;
    endtask

    task automatic clear_rom();
        int a;
        for (a = 0; a < 4096; a++)
            rom[a] = {4'hF, a[11:0]};   // Nop, low bits follow the address
    endtask

    task automatic check_addr(input string name, input logic [`DSP_AW-1:0] exp,
                              input logic [`DSP_AW-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input logic [`DSP_AW-1:0] exp);
        checks++;
        if (reg_dout !== exp) begin
            errors++;
            $display("Mismatch %s: expected register %h, actual %h", name, exp, reg_dout);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic step_to(input string name, input logic [`DSP_AW-1:0] exp);
        tick();
        check_addr(name, exp, rom_addr);
    endtask

    // Pulses irq at address from and waits for the vector fetch,
    // returning the sequential address that the vector replaced
    task automatic wait_for_vector(input string name, input logic [`DSP_AW-1:0] from,
                                   output logic [`DSP_AW-1:0] resume);
        int   n;
        logic hit;
        hit    = 1'b0;
        resume = from + 16'd1;
        irq    = 1'b1;
        for (n = 0; n < 4 && !hit; n++) begin
            tick();
            irq = 1'b0;
            if (rom_addr == `DSP_IRQ_VEC) begin
                hit = 1'b1;
            end else begin
                check_addr(name, resume, rom_addr);
                resume = resume + 16'd1;
            end
        end
        checks++;
        if (!hit) begin
            errors++;
            $display("%s: interrupt vector not fetched within four cycles of the request", name);
        end
    endtask

    task automatic sequential_fetch();
        int k;
        clear_rom();
        apply_reset();
        check_addr("reset_pc", '0, rom_addr);
        check_addr("reset_pt", '0, pt_addr);
        check_reg("reset_reg", '0);
        check_flag("reset_lfsr", 1'b0, lfsr_rst);
        for (k = 1; k <= 12; k++)
            step_to("seq_fetch", k[`DSP_AW-1:0]);
    endtask

    task automatic jumps_and_calls();
        clear_rom();
        rom[12'h000] = 16'h0010;   // goto 0x010
        rom[12'h010] = 16'h1020;   // call 0x020
        rom[12'h020] = 16'h2001;   // Return, r selects pr
        rom[12'h011] = 16'h4000;
        rom[12'h012] = 16'h0030;
        rom[12'h013] = 16'h2200;   // goto pt
        rom[12'h030] = 16'h4000;
        rom[12'h031] = 16'h0050;
        rom[12'h032] = 16'h2300;   // call pt
        rom[12'h050] = 16'h2001;
        rom[12'h033] = 16'h4000;
        rom[12'h034] = 16'h1008;   // Target in the next 4K page
        rom[12'h035] = 16'h2200;
        rom[12'h008] = 16'h00AB;   // goto ja keeps the page bits
        apply_reset();
        step_to("goto_ja", 16'h0010);
        step_to("call_ja", 16'h0020);
        check_reg("call_ja_pr", 16'h0011);
        step_to("return", 16'h0011);
        step_to("imm_pt", 16'h0012);
        step_to("imm_pt", 16'h0013);
        step_to("goto_pt", 16'h0030);
        step_to("imm_pt", 16'h0031);
        step_to("imm_pt", 16'h0032);
        step_to("call_pt", 16'h0050);
        check_reg("call_pt_pr", 16'h0033);
        step_to("return_pt", 16'h0033);
        step_to("imm_pt", 16'h0034);
        step_to("imm_pt", 16'h0035);
        step_to("goto_pt_page", 16'h1008);
        step_to("goto_ja_page", 16'h10AB);
    endtask

    task automatic register_loads();
        logic [`DSP_AW-1:0] ram_val;
        logic [`DSP_AW-1:0] acc_val;
        ram_val = $random(seed);
        acc_val = $random(seed);
        clear_rom();
        rom[0] = 16'h4003;   // i from the next word
        rom[1] = 16'h0FFE;   // Data, a goto if it were executed
        rom[2] = 16'hF003;
        rom[3] = 16'h5001;   // pr from RAM
        rom[4] = 16'hF001;
        rom[5] = 16'h6000;   // pt from the accumulator
        rom[6] = 16'hF000;
        rom[7] = 16'h4002;   // pi tracks pc in normal flow
        rom[8] = 16'h1234;
        rom[9] = 16'hF002;
        ram_dout = ram_val;
        acc_dout = acc_val;
        apply_reset();
        step_to("imm_data", 16'h0001);
        step_to("imm_skip", 16'h0002);
        check_reg("imm_i_sext", 16'hFFFE);
        step_to("ram_load", 16'h0003);
        step_to("ram_load", 16'h0004);
        check_reg("ram_pr", ram_val);
        step_to("acc_load", 16'h0005);
        step_to("acc_load", 16'h0006);
        check_reg("acc_pt", acc_val);
        check_addr("acc_pt_addr", acc_val, pt_addr);
        step_to("imm_pi", 16'h0007);
        step_to("imm_pi", 16'h0008);
        step_to("imm_pi", 16'h0009);
        check_reg("pi_shadow", 16'h0008);
        check_flag("lfsr_set", 1'b1, lfsr_rst);
        step_to("imm_pi", 16'h000A);
        check_flag("lfsr_clear", 1'b0, lfsr_rst);
    endtask

    task automatic table_reads();
        clear_rom();
        rom[0] = 16'h4000;
        rom[1] = 16'h5FFE;   // pt near the top of its low part
        rom[2] = 16'h4003;
        rom[3] = 16'h0003;   // i = 3
        rom[4] = 16'h7000;   // *pt++
        rom[5] = 16'h7000;
        rom[6] = 16'h7010;   // *pt++i
        rom[7] = 16'h7010;
        apply_reset();
        step_to("table_setup", 16'h0001);
        step_to("table_setup", 16'h0002);
        check_addr("pt_loaded", 16'h5FFE, pt_addr);
        step_to("table_setup", 16'h0003);
        step_to("table_setup", 16'h0004);
        step_to("table_read", 16'h0005);
        check_addr("pt_inc", 16'h5FFF, pt_addr);
        step_to("table_read", 16'h0006);
        check_addr("pt_wrap", 16'h5000, pt_addr);
        step_to("table_read", 16'h0007);
        check_addr("pt_istep", 16'h5003, pt_addr);
        step_to("table_read", 16'h0008);
        check_addr("pt_istep", 16'h5006, pt_addr);
    endtask

    task automatic do_loops();
        int p;
        int j;
        clear_rom();
        rom[0] = 16'h8110;   // Body of 1, 17 passes
        rom[2] = 16'h8300;   // Body of 3, 48 passes
        apply_reset();
        for (p = 0; p < 17; p++)
            step_to("do_short", 16'h0001);
        step_to("do_short_exit", 16'h0002);
        for (p = 0; p < 48; p++)
            for (j = 0; j < 3; j++)
                step_to("do_body3", 16'h0003 + j[`DSP_AW-1:0]);
        step_to("do_body3_exit", 16'h0006);
    endtask

    task automatic interrupts();
        logic [`DSP_AW-1:0] resume;
        clear_rom();
        rom[12'h000] = 16'h0100;
        rom[12'h001] = 16'h2100;   // Interrupt handler, iret only
        rom[12'h002] = 16'h2100;   // icall handler
        rom[12'h100] = 16'h3000;   // icall
        apply_reset();
        step_to("boot_jump", 16'h0100);
        step_to("icall", `DSP_ICALL_VEC);
        step_to("icall_return", 16'h0101);
        wait_for_vector("irq_entry", 16'h0101, resume);
        step_to("irq_return", resume);
        step_to("irq_resume", resume + 16'd1);
        wait_for_vector("irq_again", resume + 16'd1, resume);   // In-service cleared by iret
        step_to("irq_again_return", resume);
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        cen      = 1'b1;
        irq      = 1'b0;
        ram_dout = '0;
        acc_dout = '0;
        sequential_fetch();
        jumps_and_calls();
        register_loads();
        table_reads();
        do_loops();
        interrupts();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * 20);
        $display("Watchdog expired after %0d cycles, tests did not finish", TEST_CYCLES + MARGIN);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/dsp_seq_top.sv
// ROM, RAM and accumulator live outside; the ROM must answer within the same cycle
`timescale 1ns/1ps
`default_nettype none
`include "dsp_seq_settings.svh"

module dsp_seq_top import dsp_seq_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               irq,
    input  logic [`DSP_AW-1:0] rom_dout,
    input  logic [`DSP_AW-1:0] ram_dout,
    input  logic [`DSP_AW-1:0] acc_dout,
    output logic [`DSP_AW-1:0] rom_addr,
    output logic [`DSP_AW-1:0] pt_addr,
    output logic [`DSP_AW-1:0] reg_dout,
    output logic               lfsr_rst
);
    aau_ctl_t   ctl;
    do_ctl_t    loop;
    logic       do_start;
    logic [7:0] do_data;
    logic       do_active;
    logic       iret;
    logic       imm_pending;
    logic       irq_start;

    dsp_decoder u_dec (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .rom_dout    (rom_dout),
        .do_active   (do_active),
        .ctl         (ctl),
        .do_start    (do_start),
        .do_data     (do_data),
        .iret        (iret),
        .imm_pending (imm_pending)
    );

    dsp_do_loop u_loop (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .do_start  (do_start),
        .do_data   (do_data),
        .loop      (loop),
        .do_active (do_active)
    );

    dsp_irq_ctl u_irq (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .irq         (irq),
        .iret        (iret),
        .imm_pending (imm_pending),
        .do_active   (do_active),
        .irq_start   (irq_start)
    );

    dsp_rom_aau u_aau (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .ctl       (ctl),
        .loop      (loop),
        .irq_start (irq_start),
        .rom_dout  (rom_dout),
        .ram_dout  (ram_dout),
        .acc_dout  (acc_dout),
        .rom_addr  (rom_addr),
        .pt_addr   (pt_addr),
        .reg_dout  (reg_dout),
        .lfsr_rst  (lfsr_rst)
    );

endmodule

`default_nettype wire

// File: hdl/dsp_irq_ctl.sv
// Edge-triggered request; a second edge during service waits until interrupt return
`timescale 1ns/1ps
`default_nettype none

module dsp_irq_ctl (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    input  logic irq,
    input  logic iret,
    input  logic imm_pending,
    input  logic do_active,
    output logic irq_start
);
    logic [1:0] sync;
    logic       sync_q;        // Previous synchronized level
    logic       pending;
    logic       in_service;

    assign irq_start = pending && !in_service && !imm_pending && !do_active;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sync       <= 2'b00;
            sync_q     <= 1'b0;
            pending    <= 1'b0;
            in_service <= 1'b0;
        end else if (cen) begin
            sync   <= {sync[0], irq};
            sync_q <= sync[1];
            if (sync[1] && !sync_q)
                pending <= 1'b1;
            else if (irq_start)
                pending <= 1'b0;
            if (irq_start)
                in_service <= 1'b1;
            else if (iret)
                in_service <= 1'b0;
        end
    end

    // No second entry before the handler returns
    a_single_service: assert property (@(posedge clk) disable iff (rst)
        cen && irq_start |=> !irq_start until (cen && iret));

endmodule

`default_nettype wire

// File: hdl/dsp_do_loop.sv
// Single loop level only; count and body length must both be nonzero
`timescale 1ns/1ps
`default_nettype none

module dsp_do_loop import dsp_seq_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       do_start,
    input  logic [7:0] do_data,
    output do_ctl_t    loop,
    output logic       do_active
);
    logic [3:0] len_q;
    logic [3:0] ofs_q;
    logic [6:0] rem_q;     // Passes left after the current one
    logic       first_q;
    logic       active_q;
    logic       last;

    assign last      = active_q && ofs_q == len_q - 4'd1;
    assign do_active = active_q;

    always_comb begin
        loop.do_start = do_start;
        loop.do_redo  = active_q && rem_q != 7'd0;
        loop.do_out   = last && rem_q == 7'd0;
        loop.do_save  = active_q && first_q;
        loop.do_short = active_q && len_q == 4'd1;
        loop.do_pc    = ofs_q;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            len_q    <= 4'd0;
            ofs_q    <= 4'd0;
            rem_q    <= 7'd0;
            first_q  <= 1'b0;
            active_q <= 1'b0;
        end else if (cen) begin
            if (do_start) begin
                active_q <= 1'b1;
                first_q  <= 1'b1;
                ofs_q    <= 4'd0;
                len_q    <= do_data[7:4];
                rem_q    <= do_data[6:0] - 7'd1;
            end else if (active_q) begin
                if (last) begin
                    ofs_q   <= 4'd0;
                    first_q <= 1'b0;
                    if (rem_q == 7'd0)
                        active_q <= 1'b0;   // Exit after final pass
                    else
                        rem_q <= rem_q - 7'd1;
                end else begin
                    ofs_q <= ofs_q + 4'd1;
                end
            end
        end
    end

    a_count_nonzero: assert property (@(posedge clk) disable iff (rst)
        cen && do_start |-> do_data[6:0] != 7'd0 && do_data[7:4] != 4'd0);

endmodule

`default_nettype wire

// File: hdl/dsp_decoder.sv
// Nested do loops are not decoded; the word after an immediate-load opcode is always data
`timescale 1ns/1ps
`default_nettype none
`include "dsp_seq_settings.svh"

module dsp_decoder import dsp_seq_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic [`DSP_AW-1:0] rom_dout,
    input  logic               do_active,
    output aau_ctl_t           ctl,
    output logic               do_start,
    output logic [7:0]         do_data,
    output logic               iret,
    output logic               imm_pending
);
    instr_u     word;
    opcode_e    op;
    logic       pend_q;      // Current word is immediate data
    logic [2:0] pend_r;
    logic       fresh;

    assign word  = rom_dout;
    assign op    = word.br.op;
    assign fresh = !pend_q;

    assign do_start = fresh && op == OP_DO && !do_active;
    assign do_data  = {word.opr.hi, word.opr.cnt};   // Length in 7:4, count in 6:0
    assign iret     = fresh && op == OP_GOTO_B && word.br.ja[10:8] == 3'd1;
    // Both words of an immediate load and the do word stay uninterrupted
    assign imm_pending = pend_q || (fresh && (op == OP_IMM || op == OP_DO));

    always_comb begin
        ctl = '0;
        if (pend_q) begin
            ctl.imm_load = 1'b1;
            ctl.r        = pend_r;
            ctl.pt_load  = pend_r == 3'd0;
        end else begin
            ctl.r = word.opr.r;
            ctl.i = word.br.ja;
            case (op)
                OP_GOTO_JA: ctl.goto_ja = 1'b1;
                OP_CALL_JA: ctl.call_ja = 1'b1;
                OP_GOTO_B:  ctl.goto_b  = 1'b1;
                OP_ICALL:   ctl.icall   = 1'b1;
                OP_RAM: begin
                    ctl.ram_load = 1'b1;
                    ctl.pt_load  = word.opr.r == 3'd0;
                end
                OP_ACC: begin
                    ctl.acc_load = 1'b1;
                    ctl.pt_load  = word.opr.r == 3'd0;
                end
                OP_TABLE: begin
                    ctl.pt_read = 1'b1;
                    ctl.istep   = word.opr.cnt[0];
                end
                default: ;   // Immediate first word, do and nop
            endcase
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            pend_q <= 1'b0;
        else if (cen)
            pend_q <= fresh && op == OP_IMM;
    end

    always_ff @(posedge clk) begin
        if (cen && fresh)
            pend_r <= word.opr.r;
    end

    a_no_nested_do: assert property (@(posedge clk) disable iff (rst)
        cen && fresh && op == OP_DO |-> !do_active);

endmodule

`default_nettype wire

// File: hdl/dsp_rom_aau.sv
// Jumps inside a loop body are not supported; pt only steps within its low 12 bits
`timescale 1ns/1ps
`default_nettype none
`include "dsp_seq_settings.svh"

module dsp_rom_aau import dsp_seq_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  aau_ctl_t           ctl,
    input  do_ctl_t            loop,
    input  logic               irq_start,
    input  logic [`DSP_AW-1:0] rom_dout,
    input  logic [`DSP_AW-1:0] ram_dout,
    input  logic [`DSP_AW-1:0] acc_dout,
    output logic [`DSP_AW-1:0] rom_addr,
    output logic [`DSP_AW-1:0] pt_addr,
    output logic [`DSP_AW-1:0] reg_dout,
    output logic               lfsr_rst
);
    localparam logic [`DSP_AW-1:0] IRQ_VEC   = `DSP_IRQ_VEC;
    localparam logic [`DSP_AW-1:0] ICALL_VEC = `DSP_ICALL_VEC;

    logic [`DSP_AW-1:0] pc;
    logic [`DSP_AW-1:0] pr;
    logic [`DSP_AW-1:0] pi;
    logic [`DSP_AW-1:0] pt;
    logic [`DSP_AW-1:0] head;       // Address of the first body word
    logic [`DSP_IW-1:0] i;
    logic [`DSP_AW-1:0] seq_pc;
    logic [`DSP_AW-1:0] target;
    logic [`DSP_AW-1:0] next_pc;
    logic [`DSP_AW-1:0] next_pt;
    logic [`DSP_AW-1:0] load_val;
    logic [2:0]         b_field;
    logic               shadow;     // Normal flow, pi tracks pc
    logic               irq_in;
    logic               in_cache;
    logic               replay;
    logic               ret;
    logic               iret;
    logic               goto_pt;
    logic               call_pt;
    logic               any_load;
    logic               load_pr;
    logic               load_pi;
    logic               load_i;

    assign seq_pc   = pc + 1'b1;
    assign b_field  = ctl.i[10:8];
    assign ret      = ctl.goto_b && b_field == 3'd0;
    assign iret     = ctl.goto_b && b_field == 3'd1;
    assign goto_pt  = ctl.goto_b && b_field == 3'd2;
    assign call_pt  = ctl.goto_b && b_field == 3'd3;
    assign any_load = ctl.ram_load || ctl.imm_load || ctl.acc_load;
    assign load_pr  = any_load && ctl.r == 3'd1;
    assign load_pi  = any_load && ctl.r == 3'd2;
    assign load_i   = any_load && ctl.r == 3'd3;

    // First pass runs from pc, later passes come from the head
    assign replay   = in_cache && !loop.do_save;
    assign rom_addr = replay ? head + {{(`DSP_AW-4){1'b0}}, loop.do_pc} : pc;
    assign pt_addr  = pt;

    always_comb begin
        load_val = ctl.imm_load ? rom_dout : (ctl.ram_load ? ram_dout : acc_dout);
        next_pt  = {pt[`DSP_AW-1:`DSP_IW], pt[`DSP_IW-1:0] + (ctl.istep ? i : `DSP_IW'd1)};

        if (replay)
            target = pc;            // pc already holds the exit address
        else if (ctl.icall)
            target = ICALL_VEC;
        else if (ctl.goto_ja || ctl.call_ja)
            target = {pc[`DSP_AW-1:`DSP_IW], ctl.i};
        else if (goto_pt || call_pt)
            target = pt;
        else if (ret)
            target = pr;
        else if (iret)
            target = pi;
        else
            target = seq_pc;
        next_pc = (irq_start && !replay) ? IRQ_VEC : target;

        case (ctl.r[1:0])
            2'd0: reg_dout = pt;
            2'd1: reg_dout = pr;
            2'd2: reg_dout = pi;
            default: reg_dout = {{(`DSP_AW-`DSP_IW){i[`DSP_IW-1]}}, i};
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pc       <= '0;
            pr       <= '0;
            pi       <= '0;
            pt       <= '0;
            i        <= '0;
            shadow   <= 1'b1;
            irq_in   <= 1'b0;
            in_cache <= 1'b0;
            lfsr_rst <= 1'b0;
        end else if (cen) begin
            pc <= next_pc;
            if (ctl.pt_load)
                pt <= load_val;
            else if (ctl.pt_read)
                pt <= next_pt;
            if (ctl.call_ja || call_pt)
                pr <= seq_pc;   // Return address
            else if (load_pr)
                pr <= load_val;
            if (load_i)
                i <= load_val[`DSP_IW-1:0];

            if (irq_start)
                pi <= target;   // Resume where this word would have gone
            else if (ctl.icall)
                pi <= seq_pc;
            else if (shadow && !loop.do_start)
                pi <= pc;
            else if (load_pi)
                pi <= load_val;
            // Writing pi during normal flow resets the LFSR instead
            lfsr_rst <= shadow && load_pi && !irq_start && !ctl.icall && !loop.do_start;

            if (irq_start || ctl.icall || loop.do_start)
                shadow <= 1'b0;
            else if (iret || (loop.do_out && !irq_in))
                shadow <= 1'b1;
            if (irq_start || ctl.icall)
                irq_in <= 1'b1;
            else if (iret)
                irq_in <= 1'b0;

            if (loop.do_out)
                in_cache <= 1'b0;
            else if (loop.do_save && loop.do_redo)
                in_cache <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cen && loop.do_save && loop.do_pc == 4'd0)
            head <= pc;
    end

    a_one_source: assert property (@(posedge clk) disable iff (rst)
        cen |-> $onehot0({ctl.ram_load, ctl.imm_load, ctl.acc_load}));

    // Held pc marks the end of the body
    a_loop_window: assert property (@(posedge clk) disable iff (rst)
        replay |-> (rom_addr - head) < (pc - head)
                   && (!loop.do_short || pc - head == `DSP_AW'd1));

endmodule

`default_nettype wire

// File: hdl/dsp_seq_pkg.sv
// Field layout assumes DSP_AW equals DSP_IW plus 4; loop bodies hold at most 15 words
`default_nettype none
`include "dsp_seq_settings.svh"

package dsp_seq_pkg;

    typedef enum logic [3:0] {
        OP_GOTO_JA = 4'd0,
        OP_CALL_JA = 4'd1,
        OP_GOTO_B  = 4'd2,   // b field picks return, iret, goto pt or call pt
        OP_ICALL   = 4'd3,
        OP_IMM     = 4'd4,   // Value comes in the next ROM word
        OP_RAM     = 4'd5,
        OP_ACC     = 4'd6,
        OP_TABLE   = 4'd7,   // *pt++ or *pt++i
        OP_DO      = 4'd8,
        OP_NOP     = 4'd15
    } opcode_e;

    // Jumps and calls
    typedef struct packed {
        opcode_e             op;
        logic [`DSP_IW-1:0]  ja;     // b field in bits 10:8
    } branch_view_t;

    // Loads, table reads and do loops
    typedef struct packed {
        opcode_e     op;
        logic        hi;      // Body length is {hi, cnt[6:4]}
        logic [6:0]  cnt;     // Repeat count, istep in bit 0
        logic        spare;
        logic [2:0]  r;
    } operand_view_t;

    typedef union packed {
        branch_view_t   br;
        operand_view_t  opr;
    } instr_u;

    typedef struct packed {
        logic                goto_ja;
        logic                goto_b;
        logic                call_ja;
        logic                icall;
        logic                ram_load;
        logic                imm_load;
        logic                acc_load;
        logic                pt_load;    // Write pt from the selected source
        logic                pt_read;    // Post-increment pt
        logic                istep;
        logic [2:0]          r;
        logic [`DSP_IW-1:0]  i;
    } aau_ctl_t;

    typedef struct packed {
        logic        do_start;
        logic        do_redo;
        logic        do_out;
        logic        do_save;
        logic        do_short;
        logic [3:0]  do_pc;
    } do_ctl_t;

endpackage

`default_nettype wire

// File: include/dsp_seq_settings.svh
// Assumes a 16-bit word split into a 4-bit opcode and a 12-bit field; both vectors sit in page 0
`ifndef DSP_SEQ_SETTINGS_SVH
`define DSP_SEQ_SETTINGS_SVH

// Program and table address width, one ROM word
`define DSP_AW 16

// Width of the i register and of the jump field
`define DSP_IW 12

// Entry point taken when the interrupt controller fires
`define DSP_IRQ_VEC 1

// Entry point of icall
`define DSP_ICALL_VEC 2

`endif
